//--- hw/game_pkg.sv
`default_nettype none

package game_pkg;

    // Screen coordinate in pixels.
    typedef logic [9:0] coord_t;

    // Per-frame velocity, negative values move left or up.
    typedef logic signed [3:0] delta_t;

    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    // Every sprite uses the same bounding box.
    localparam int SPRITE_W = 16;
    localparam int SPRITE_H = 16;

    // Round sequencing states.
    typedef enum logic [2:0]
    {
        START,
        AIM,
        SHOOT,
        WON,
        WON_END,
        LOST,
        LOST_END
    } game_state_t;

endpackage

`default_nettype wire

//--- hw/game_sprite.sv
`timescale 1ns/1ps
`default_nettype none

module game_sprite
#(
    parameter game_pkg::coord_t START_X = '0,
    parameter game_pkg::coord_t START_Y = '0,
    parameter game_pkg::delta_t VEL_X   = '0,
    parameter game_pkg::delta_t VEL_Y   = '0
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             frame_tick,

    input  logic             write_xy,
    input  logic             write_dxy,
    input  logic             enable_update,

    output game_pkg::coord_t x,
    output game_pkg::coord_t y,
    output logic             within_screen
);

    import game_pkg::*;

    delta_t dx;
    delta_t dy;

    // The cast sign-extends the velocity, so a negative step wraps the
    // coordinate downwards modulo 1024.
    coord_t step_x;
    coord_t step_y;

    assign step_x = coord_t'(dx);
    assign step_y = coord_t'(dy);

    // Reset puts the sprite where a START load would, so the first round
    // after reset begins from the same place as every later one.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            x <= START_X;
            y <= START_Y;
        end
        else if (write_xy)
        begin
            x <= START_X;
            y <= START_Y;
        end
        else if (enable_update && frame_tick)
        begin
            x <= x + step_x;  // One step per frame.
            y <= y + step_y;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            dx <= VEL_X;
            dy <= VEL_Y;
        end
        else if (write_dxy)
        begin
            dx <= VEL_X;
            dy <= VEL_Y;
        end
    end

    // A coordinate that wrapped below zero is large, so one upper bound
    // check covers both edges of each axis.
    assign within_screen = (int'(x) + SPRITE_W <= SCREEN_W)
                        && (int'(y) + SPRITE_H <= SCREEN_H);

endmodule

`default_nettype wire

//--- hw/game_overlap.sv
`timescale 1ns/1ps
`default_nettype none

module game_overlap
(
    input  logic             clk,
    input  logic             reset,

    input  game_pkg::coord_t a_x,
    input  game_pkg::coord_t a_y,
    input  game_pkg::coord_t b_x,
    input  game_pkg::coord_t b_y,

    output logic             collision
);

    import game_pkg::*;

    logic overlap_x;
    logic overlap_y;

    // Two boxes of equal size intersect on an axis when each one starts
    // before the other one ends.
    assign overlap_x = (int'(a_x) < int'(b_x) + SPRITE_W)
                    && (int'(b_x) < int'(a_x) + SPRITE_W);

    assign overlap_y = (int'(a_y) < int'(b_y) + SPRITE_H)
                    && (int'(b_y) < int'(a_y) + SPRITE_H);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= overlap_x && overlap_y;  // One cycle behind the positions.
    end

endmodule

`default_nettype wire

//--- hw/game_end_timer.sv
`timescale 1ns/1ps
`default_nettype none

module game_end_timer
#(
    parameter int END_TICKS = 8
)
(
    input  logic clk,
    input  logic reset,
    input  logic frame_tick,
    input  logic start,
    output logic running
);

    localparam int CW = $clog2(END_TICKS + 1);

    logic [CW - 1:0] count;

    // A start pulse wins over a frame tick in the same cycle.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= CW'(END_TICKS);
        else if (frame_tick && count != '0)
            count <= count - 1'b1;
    end

    assign running = (count != '0);

endmodule

`default_nettype wire

//--- hw/game_master_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_master_fsm
(
    input  logic clk,
    input  logic reset,

    input  logic key,
    input  logic collision,
    input  logic target_within_screen,
    input  logic torpedo_within_screen,
    input  logic timer_running,

    output logic target_write_xy,
    output logic torpedo_write_xy,
    output logic target_write_dxy,
    output logic torpedo_write_dxy,
    output logic target_enable_update,
    output logic torpedo_enable_update,
    output logic timer_start,
    output logic game_won
);

    import game_pkg::*;

    game_state_t state;
    game_state_t n_state;

    logic after_start;
    logic hit;
    logic out_of_screen;

    // Collision is registered, so in the first AIM cycle it still reflects
    // the frozen positions of the previous round and must be ignored.
    assign hit           = collision && !after_start;
    assign out_of_screen = !target_within_screen || !torpedo_within_screen;

    always_comb
    begin
        n_state = state;

        unique case (state)
            START:    n_state = AIM;
            AIM:
            begin
                if (key)
                    n_state = SHOOT;
                else if (hit)
                    n_state = WON;
                else if (out_of_screen)
                    n_state = LOST;
            end
            SHOOT:
            begin
                if (hit)
                    n_state = WON;
                else if (out_of_screen)
                    n_state = LOST;
            end
            WON:      n_state = WON_END;
            WON_END:  n_state = timer_running ? WON_END : START;
            LOST:     n_state = LOST_END;
            LOST_END: n_state = timer_running ? LOST_END : START;
            default:  n_state = START;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= START;
            after_start <= 1'b0;
        end
        else
        begin
            state       <= n_state;
            after_start <= (state == START);
        end
    end

    // Outputs follow the next state, so they line up with the state itself.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            target_write_xy       <= 1'b0;
            torpedo_write_xy      <= 1'b0;
            target_write_dxy      <= 1'b0;
            torpedo_write_dxy     <= 1'b0;
            target_enable_update  <= 1'b0;
            torpedo_enable_update <= 1'b0;
            timer_start           <= 1'b0;
            game_won              <= 1'b0;
        end
        else
        begin
            target_write_xy       <= (n_state == START);
            torpedo_write_xy      <= (n_state == START);
            target_write_dxy      <= (n_state == START);
            torpedo_write_dxy     <= (n_state == SHOOT);  // Torpedo is fired.
            target_enable_update  <= (n_state == AIM) || (n_state == SHOOT);
            torpedo_enable_update <= (n_state == SHOOT);
            timer_start           <= (n_state == WON) || (n_state == LOST);
            game_won              <= (n_state == WON) || (n_state == WON_END);
        end
    end

endmodule

`default_nettype wire

//--- hw/game_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_top
#(
    parameter game_pkg::coord_t TARGET_START_X  = 10'd16,
    parameter game_pkg::coord_t TARGET_START_Y  = 10'd48,
    parameter game_pkg::delta_t TARGET_VEL_X    = 4'sd2,
    parameter game_pkg::delta_t TARGET_VEL_Y    = 4'sd0,
    parameter game_pkg::coord_t TORPEDO_START_X = 10'd312,
    parameter game_pkg::coord_t TORPEDO_START_Y = 10'd448,
    parameter game_pkg::delta_t TORPEDO_VEL_X   = 4'sd0,
    parameter game_pkg::delta_t TORPEDO_VEL_Y   = -4'sd3,
    parameter int               END_TICKS       = 8
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             key,
    input  logic             frame_tick,

    output logic             game_won,
    output logic             game_over,  // High while the result is held.

    output game_pkg::coord_t target_x,
    output game_pkg::coord_t target_y,
    output game_pkg::coord_t torpedo_x,
    output game_pkg::coord_t torpedo_y
);

    logic target_write_xy;
    logic torpedo_write_xy;
    logic target_write_dxy;
    logic torpedo_write_dxy;
    logic target_enable_update;
    logic torpedo_enable_update;
    logic target_within_screen;
    logic torpedo_within_screen;
    logic collision;
    logic timer_start;

    game_sprite
    #(
        .START_X (TARGET_START_X),
        .START_Y (TARGET_START_Y),
        .VEL_X   (TARGET_VEL_X),
        .VEL_Y   (TARGET_VEL_Y)
    )
    u_target
    (
        .clk           (clk),
        .reset         (reset),
        .frame_tick    (frame_tick),
        .write_xy      (target_write_xy),
        .write_dxy     (target_write_dxy),
        .enable_update (target_enable_update),
        .x             (target_x),
        .y             (target_y),
        .within_screen (target_within_screen)
    );

    game_sprite
    #(
        .START_X (TORPEDO_START_X),
        .START_Y (TORPEDO_START_Y),
        .VEL_X   (TORPEDO_VEL_X),
        .VEL_Y   (TORPEDO_VEL_Y)
    )
    u_torpedo
    (
        .clk           (clk),
        .reset         (reset),
        .frame_tick    (frame_tick),
        .write_xy      (torpedo_write_xy),
        .write_dxy     (torpedo_write_dxy),
        .enable_update (torpedo_enable_update),
        .x             (torpedo_x),
        .y             (torpedo_y),
        .within_screen (torpedo_within_screen)
    );

    game_overlap u_overlap
    (
        .clk       (clk),
        .reset     (reset),
        .a_x       (target_x),
        .a_y       (target_y),
        .b_x       (torpedo_x),
        .b_y       (torpedo_y),
        .collision (collision)
    );

    game_end_timer #(.END_TICKS (END_TICKS)) u_end_timer
    (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .start      (timer_start),
        .running    (game_over)
    );

    game_master_fsm u_master_fsm
    (
        .clk                   (clk),
        .reset                 (reset),
        .key                   (key),
        .collision             (collision),
        .target_within_screen  (target_within_screen),
        .torpedo_within_screen (torpedo_within_screen),
        .timer_running         (game_over),
        .target_write_xy       (target_write_xy),
        .torpedo_write_xy      (torpedo_write_xy),
        .target_write_dxy      (target_write_dxy),
        .torpedo_write_dxy     (torpedo_write_dxy),
        .target_enable_update  (target_enable_update),
        .torpedo_enable_update (torpedo_enable_update),
        .timer_start           (timer_start),
        .game_won              (game_won)
    );

endmodule

`default_nettype wire

//--- verif/game_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module game_asserts
(
    input logic                  clk,
    input logic                  reset,
    input game_pkg::game_state_t state,
    input logic                  timer_start,
    input logic                  game_won
);

    import game_pkg::*;

    // The three-bit encoding leaves one code that the FSM must never reach.
    state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {START, AIM, SHOOT, WON, WON_END, LOST, LOST_END})
        else $error("FSM state holds an undefined encoding.");

    timer_start_pulse: assert property (@(posedge clk) disable iff (reset)
        timer_start |=> !timer_start)
        else $error("timer_start stayed high for more than one cycle.");

    // A lost round never shows the won flag.
    no_won_when_lost: assert property (@(posedge clk) disable iff (reset)
        (state == LOST || state == LOST_END) |-> !game_won)
        else $error("game_won is high in a LOST state.");

endmodule

`default_nettype wire

//--- verif/game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module game_tb;

    import game_pkg::*;

    localparam coord_t T_X0      = 10'd16;
    localparam coord_t T_Y0      = 10'd48;
    localparam delta_t T_VX      = 4'sd2;
    localparam delta_t T_VY      = 4'sd0;
    localparam coord_t P_X0      = 10'd312;
    localparam coord_t P_Y0      = 10'd448;
    localparam delta_t P_VX      = 4'sd0;
    localparam delta_t P_VY      = -4'sd3;
    localparam int     END_TICKS = 8;

    localparam int     KEY_LOW  = 0;
    localparam int     KEY_HIGH = 1;
    localparam int     KEY_RAND = 2;

    // Firing with the target near here lets the torpedo meet it at the target's row.
    localparam coord_t FIRE_X       = 10'd50;
    localparam int     ROUND_LIMIT  = 5000;
    localparam int     HOLD_LIMIT   = 200;
    localparam int     RANDOM_ROUNDS = 4;

    logic   clk;
    logic   reset;
    logic   key;
    logic   frame_tick;
    logic   game_won;
    logic   game_over;
    coord_t target_x;
    coord_t target_y;
    coord_t torpedo_x;
    coord_t torpedo_y;

    logic [31:0] lfsr;
    string       test_name;

    // Reference model of the game, one update per clock edge.
    game_state_t m_state;
    logic        m_after_start;
    logic        m_load;
    logic        m_t_en;
    logic        m_p_en;
    logic        m_tstart;
    logic        m_won;
    logic        m_coll;
    coord_t      m_tx;
    coord_t      m_ty;
    coord_t      m_px;
    coord_t      m_py;
    int          m_count;

    game_top
    #(
        .TARGET_START_X  (T_X0),
        .TARGET_START_Y  (T_Y0),
        .TARGET_VEL_X    (T_VX),
        .TARGET_VEL_Y    (T_VY),
        .TORPEDO_START_X (P_X0),
        .TORPEDO_START_Y (P_Y0),
        .TORPEDO_VEL_X   (P_VX),
        .TORPEDO_VEL_Y   (P_VY),
        .END_TICKS       (END_TICKS)
    )
    u_game_top
    (
        .clk        (clk),
        .reset      (reset),
        .key        (key),
        .frame_tick (frame_tick),
        .game_won   (game_won),
        .game_over  (game_over),
        .target_x   (target_x),
        .target_y   (target_y),
        .torpedo_x  (torpedo_x),
        .torpedo_y  (torpedo_y)
    );

    bind game_master_fsm game_asserts u_asserts
    (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .timer_start (timer_start),
        .game_won    (game_won)
    );

    always #2 clk = ~clk;  // 4 ns period.

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b    = lfsr[0];
    endtask

    function automatic coord_t step_of(input delta_t d);
        return {{6{d[3]}}, d};  // Negative steps wrap modulo 1024.
    endfunction

    // The box origin may go no further than one box size short of each edge.
    function automatic logic fits_screen(input coord_t x, input coord_t y);
        return (int'(x) <= SCREEN_W - SPRITE_W) && (int'(y) <= SCREEN_H - SPRITE_H);
    endfunction

    function automatic logic boxes_meet(input coord_t ax, input coord_t ay,
                                        input coord_t bx, input coord_t by);
        int gap_x;
        int gap_y;

        // Equal boxes share pixels when their origins lie less than one box apart.
        gap_x = (ax > bx) ? int'(ax) - int'(bx) : int'(bx) - int'(ax);
        gap_y = (ay > by) ? int'(ay) - int'(by) : int'(by) - int'(ay);
        return (gap_x < SPRITE_W) && (gap_y < SPRITE_H);
    endfunction

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s in %s.", what, test_name);
        stop_on_error();
    endtask

    task automatic check_coord(input string what, input coord_t exp, input coord_t act);
        if (act !== exp)
        begin
            $display("ERR %s %s expected %0d actual %0d", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic model_reset();
        m_state       = START;
        m_after_start = 1'b0;
        m_load        = 1'b0;
        m_t_en        = 1'b0;
        m_p_en        = 1'b0;
        m_tstart      = 1'b0;
        m_won         = 1'b0;
        m_coll        = 1'b0;
        m_tx          = T_X0;
        m_ty          = T_Y0;
        m_px          = P_X0;
        m_py          = P_Y0;
        m_count       = 0;
    endtask

    task automatic model_step(input logic k, input logic ft);
        game_state_t nxt;
        logic        hit;
        logic        gone;
        logic        coll_next;

        // A stale collision from the last round is ignored in the first AIM cycle.
        hit       = m_coll && !m_after_start;
        gone      = !fits_screen(m_tx, m_ty) || !fits_screen(m_px, m_py);
        coll_next = boxes_meet(m_tx, m_ty, m_px, m_py);
        nxt       = m_state;
        case (m_state)
            START:    nxt = AIM;
            AIM:
            begin
                if (k)
                    nxt = SHOOT;
                else if (hit)
                    nxt = WON;
                else if (gone)
                    nxt = LOST;
            end
            SHOOT:
            begin
                if (hit)
                    nxt = WON;
                else if (gone)
                    nxt = LOST;
            end
            WON:      nxt = WON_END;
            LOST:     nxt = LOST_END;
            WON_END:  nxt = (m_count != 0) ? WON_END : START;
            LOST_END: nxt = (m_count != 0) ? LOST_END : START;
            default:  nxt = START;
        endcase

        if (m_load)
        begin
            m_tx = T_X0;
            m_ty = T_Y0;
            m_px = P_X0;
            m_py = P_Y0;
        end
        else
        begin
            if (m_t_en && ft)
            begin
                m_tx = m_tx + step_of(T_VX);
                m_ty = m_ty + step_of(T_VY);
            end
            if (m_p_en && ft)
            begin
                m_px = m_px + step_of(P_VX);
                m_py = m_py + step_of(P_VY);
            end
        end

        if (m_tstart)
            m_count = END_TICKS;  // Start wins over a tick.
        else if (ft && m_count != 0)
            m_count = m_count - 1;

        m_coll        = coll_next;
        m_after_start = (m_state == START);
        m_state       = nxt;
        m_load        = (nxt == START);
        m_t_en        = (nxt == AIM) || (nxt == SHOOT);
        m_p_en        = (nxt == SHOOT);
        m_tstart      = (nxt == WON) || (nxt == LOST);
        m_won         = (nxt == WON) || (nxt == WON_END);
    endtask

    task automatic compare_outputs();
        check_flag("game_won", m_won, game_won);
        check_flag("game_over", m_count != 0, game_over);
        check_coord("target_x", m_tx, target_x);
        check_coord("target_y", m_ty, target_y);
        check_coord("torpedo_x", m_px, torpedo_x);
        check_coord("torpedo_y", m_py, torpedo_y);
    endtask

    task automatic check_start_positions();
        check_coord("target_x", T_X0, target_x);
        check_coord("target_y", T_Y0, target_y);
        check_coord("torpedo_x", P_X0, torpedo_x);
        check_coord("torpedo_y", P_Y0, torpedo_y);
    endtask

    // Inputs held since the last drive are the ones the DUT saw at this edge.
    task automatic run_cycle(input int key_mode);
        logic       ft;
        logic [4:0] kb;

        @(posedge clk);
        #1;
        model_step(key, frame_tick);
        compare_outputs();
        random_bit(ft);
        kb = '0;
        if (key_mode == KEY_RAND)
        begin
            for (int i = 0; i < 5; i++)
                random_bit(kb[i]);
        end
        key        = (key_mode == KEY_HIGH) || (key_mode == KEY_RAND && &kb);
        frame_tick = ft;
    endtask

    task automatic wait_result(input int key_mode);
        int n;

        n = 0;
        while (!game_over)
        begin
            if (n == ROUND_LIMIT)
                timeout_fail("game_over to rise");
            run_cycle(key_mode);
            n++;
        end
    endtask

    task automatic hold_result(input int key_mode);
        int n;
        int ticks;

        n     = 0;
        ticks = 0;
        while (game_over)
        begin
            if (n == HOLD_LIMIT)
                timeout_fail("game_over to fall");
            if (frame_tick)
                ticks++;
            run_cycle(key_mode);
            n++;
        end
        if (ticks != END_TICKS)
        begin
            $display("ERR %s held ticks expected %0d actual %0d", test_name, END_TICKS, ticks);
            stop_on_error();
        end
    endtask

    // The FSM enters START one edge after game_over falls, and the START
    // load lands on the sprites at the edge after that.
    task automatic check_reload();
        run_cycle(KEY_LOW);
        run_cycle(KEY_LOW);
        check_start_positions();
    endtask

    initial
    begin
        int n;

        clk        = 1'b0;
        reset      = 1'b1;
        key        = 1'b0;
        frame_tick = 1'b0;
        lfsr       = 32'he570;
        test_name  = "reset";
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        model_reset();
        check_flag("game_won", 1'b0, game_won);
        check_flag("game_over", 1'b0, game_over);
        check_start_positions();

        // The target flies off the right edge and the round is lost.
        test_name = "target_only";
        wait_result(KEY_LOW);
        check_flag("game_won", 1'b0, game_won);
        hold_result(KEY_LOW);
        check_reload();

        test_name = "torpedo_hit";
        n = 0;
        while (target_x < FIRE_X)
        begin
            if (n == ROUND_LIMIT)
                timeout_fail("the target to reach the firing point");
            run_cycle(KEY_LOW);
            n++;
        end
        run_cycle(KEY_HIGH);
        run_cycle(KEY_LOW);
        wait_result(KEY_LOW);
        check_flag("game_won", 1'b1, game_won);
        hold_result(KEY_LOW);
        check_reload();

        test_name = "random_round";
        for (int r = 0; r < RANDOM_ROUNDS; r++)
        begin
            wait_result(KEY_RAND);
            hold_result(KEY_RAND);
            check_reload();
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hw/game_pkg.sv
hw/game_sprite.sv
hw/game_overlap.sv
hw/game_end_timer.sv
hw/game_master_fsm.sv
hw/game_top.sv
verif/game_asserts.sv
verif/game_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = game_tb
FILELIST  = build.f

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
